// ==== Bender.yml ====
package:
  name: lsu

sources:
  - include_dirs:
      - source
    files:
      - source/lsu_pkg.sv
      - source/obi_pkg.sv
      - source/lsu_request_gen.sv
      - source/lsu_txn_ctrl.sv
      - source/lsu_load_align.sv
      - source/lsu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_lsu_top.sv

// ==== lsu.f ====
+incdir+source
source/lsu_pkg.sv
source/obi_pkg.sv
source/lsu_request_gen.sv
source/lsu_txn_ctrl.sv
source/lsu_load_align.sv
source/lsu_top.sv
test/tb_lsu_top.sv

// ==== source/lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

//////////////////////////////////////////////////
// Widths of the core and bus data path
//////////////////////////////////////////////////

// Data and address width
`define LSU_XLEN 32
// One enable per byte of a bus word
`define LSU_BE_W 4

// Outstanding bus transactions, and the counter that tracks them
`define LSU_DEPTH 2
`define LSU_CNT_W 2

`endif

// ==== source/lsu_load_align.sv ====
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_load_align (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rsp_load_i,
  input  logic [`LSU_XLEN-1:0]  rdata_i,
  input  lsu_pkg::lsu_wb_ctrl_t wb_ctrl_i,
  input  logic                  split_active_i,
  input  logic                  split_first_i,
  output logic [`LSU_XLEN-1:0]  rdata_o
);

  import lsu_pkg::*;

  lsu_word_u   rsp_w;
  // First word of a split load
  lsu_word_u   prev_q;
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  logic [31:0] word_sel;

  assign rsp_w = rdata_i;

  // Byte at the captured offset
  assign byte_sel = rsp_w.bytes[wb_ctrl_i.offset];

  // Even offsets read a halfword lane directly
  always_comb
  begin
    case (wb_ctrl_i.offset)
      2'b00:   half_sel = rsp_w.halves[0];
      2'b01:   half_sel = {rsp_w.bytes[2], rsp_w.bytes[1]};
      2'b10:   half_sel = rsp_w.halves[1];
      default: half_sel = {rsp_w.bytes[0], prev_q.bytes[3]};
    endcase
  end

  // Join the upper bytes of the first word with the second
  always_comb
  begin
    case (wb_ctrl_i.offset)
      2'b00:   word_sel = rsp_w;
      2'b01:   word_sel = {rsp_w.bytes[0], prev_q.bytes[3:1]};
      2'b10:   word_sel = {rsp_w.halves[0], prev_q.halves[1]};
      default: word_sel = {rsp_w.bytes[2:0], prev_q.bytes[3]};
    endcase
  end

  // Zero or sign extension
  always_comb
  begin
    case (wb_ctrl_i.size)
      LSU_BYTE: rdata_o = {{24{wb_ctrl_i.sign_ext && byte_sel[7]}}, byte_sel};
      LSU_HALF: rdata_o = {{16{wb_ctrl_i.sign_ext && half_sel[15]}}, half_sel};
      default:  rdata_o = word_sel;
    endcase
  end

  // Capture while a split access is under way
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      prev_q <= '0;
    else if (rsp_load_i && (split_active_i || split_first_i))
      prev_q <= rsp_w;
  end

endmodule

// ==== source/lsu_pkg.sv ====
`include "lsu_consts.svh"

package lsu_pkg;

  // Access size, encoded as in the funct3 low bits
  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  // Load or store from the execute stage
  typedef struct packed {
    logic                 we;
    lsu_size_e            size;
    logic                 sign_ext;
    logic [`LSU_XLEN-1:0] base;
    logic [`LSU_XLEN-1:0] offset;
    logic [`LSU_XLEN-1:0] wdata;
  } lsu_req_t;

  // Control carried from the address phase to the response
  typedef struct packed {
    lsu_size_e  size;
    logic       sign_ext;
    logic       we;
    logic [1:0] offset;
    // Cleared for the first half of a split access
    logic       last;
  } lsu_wb_ctrl_t;

  // One bus word, seen as bytes or as halfwords
  typedef union packed {
    logic [`LSU_BE_W-1:0][7:0]     bytes;
    logic [`LSU_BE_W/2-1:0][15:0]  halves;
  } lsu_word_u;

endpackage

// ==== source/lsu_request_gen.sv ====
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_request_gen (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid_i,
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              addr_done_i,
  output obi_pkg::obi_req_t bus_req_o,
  output logic              split_first_o,
  output logic              split_active_o,
  output logic [1:0]        addr_lsb_o
);

  import lsu_pkg::*;

  logic [`LSU_XLEN-1:0] addr_int;
  logic [1:0]           addr_lsb;
  logic [`LSU_BE_W-1:0] be;
  logic [`LSU_XLEN-1:0] wdata;
  // Second address phase of a split access in progress
  logic                 split_q;

  //////////////////////////////////////////////////
  // Address and split detection
  //////////////////////////////////////////////////

  // Second phase moves on to the next word
  assign addr_int = req_i.base + req_i.offset + (split_q ? `LSU_XLEN'(4) : `LSU_XLEN'(0));
  assign addr_lsb = addr_int[1:0];

  // Word off alignment, or halfword in the top byte, crosses a word
  always_comb
  begin
    split_first_o = 1'b0;
    if (req_valid_i && !split_q)
    begin
      if (req_i.size == LSU_WORD && addr_lsb != 2'b00)
        split_first_o = 1'b1;
      if (req_i.size == LSU_HALF && addr_lsb == 2'b11)
        split_first_o = 1'b1;
    end
  end

  // Cleared with no request so the next one starts in phase one
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      split_q <= 1'b0;
    else if (!req_valid_i)
      split_q <= 1'b0;
    else if (addr_done_i)
      split_q <= split_first_o;
  end

  //////////////////////////////////////////////////
  // Byte enables and store data
  //////////////////////////////////////////////////

  always_comb
  begin
    case (req_i.size)
      LSU_BYTE: be = 4'b0001 << addr_lsb;
      // Shifted-out bits give 1000 for the first half at offset 3
      LSU_HALF: be = split_q ? 4'b0001 : (4'b0011 << addr_lsb);
      // Second phase takes the bytes the first one left over
      default:  be = split_q ? ~(4'b1111 << addr_lsb) : (4'b1111 << addr_lsb);
    endcase
  end

  // Rotate store data so each byte sits on its lane
  always_comb
  begin
    case (addr_lsb)
      2'b00:   wdata = req_i.wdata;
      2'b01:   wdata = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10:   wdata = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata = {req_i.wdata[7:0], req_i.wdata[31:8]};
    endcase
  end

  // Word-aligned address for the second phase
  assign bus_req_o.req   = req_valid_i;
  assign bus_req_o.addr  = split_q ? {addr_int[`LSU_XLEN-1:2], 2'b00} : addr_int;
  assign bus_req_o.we    = req_i.we;
  assign bus_req_o.be    = be;
  assign bus_req_o.wdata = wdata;

  assign split_active_o = split_q;
  assign addr_lsb_o     = addr_lsb;

endmodule

// ==== source/lsu_top.sv ====
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req_valid_i,
  input  lsu_pkg::lsu_req_t    req_i,
  output logic                 req_ready_o,
  output obi_pkg::obi_req_t    obi_req_o,
  input  logic                 obi_gnt_i,
  input  obi_pkg::obi_rsp_t    obi_rsp_i,
  output logic                 result_valid_o,
  output logic [`LSU_XLEN-1:0] result_rdata_o,
  output logic                 err_o,
  output logic [`LSU_XLEN-1:0] err_addr_o
);

  import lsu_pkg::*;
  import obi_pkg::*;

  obi_req_t     bus_req;
  logic         split_first;
  logic         split_active;
  logic [1:0]   addr_lsb;
  logic         addr_done;
  logic         rsp_load;
  lsu_wb_ctrl_t wb_ctrl;

  //////////////////////////////////////////////////
  // Request generation
  //////////////////////////////////////////////////

  lsu_request_gen i_request_gen (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .addr_done_i    (addr_done),
    .bus_req_o      (bus_req),
    .split_first_o  (split_first),
    .split_active_o (split_active),
    .addr_lsb_o     (addr_lsb)
  );

  // Transaction control and counter
  lsu_txn_ctrl i_txn_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .bus_req_i      (bus_req),
    .req_size_i     (req_i.size),
    .req_sign_ext_i (req_i.sign_ext),
    .split_first_i  (split_first),
    .addr_lsb_i     (addr_lsb),
    .obi_gnt_i      (obi_gnt_i),
    .obi_rsp_i      (obi_rsp_i),
    .obi_req_o      (obi_req_o),
    .req_ready_o    (req_ready_o),
    .addr_done_o    (addr_done),
    .rsp_load_o     (rsp_load),
    .result_valid_o (result_valid_o),
    .err_o          (err_o),
    .wb_ctrl_o      (wb_ctrl),
    .err_addr_o     (err_addr_o)
  );

  // Read-data alignment
  lsu_load_align i_load_align (
    .clk            (clk),
    .rst_n          (rst_n),
    .rsp_load_i     (rsp_load),
    .rdata_i        (obi_rsp_i.rdata),
    .wb_ctrl_i      (wb_ctrl),
    .split_active_i (split_active),
    .split_first_i  (split_first),
    .rdata_o        (result_rdata_o)
  );

endmodule

// ==== source/lsu_txn_ctrl.sv ====
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_txn_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  obi_pkg::obi_req_t     bus_req_i,
  input  lsu_pkg::lsu_size_e    req_size_i,
  input  logic                  req_sign_ext_i,
  input  logic                  split_first_i,
  input  logic [1:0]            addr_lsb_i,
  input  logic                  obi_gnt_i,
  input  obi_pkg::obi_rsp_t     obi_rsp_i,
  output obi_pkg::obi_req_t     obi_req_o,
  output logic                  req_ready_o,
  output logic                  addr_done_o,
  output logic                  rsp_load_o,
  output logic                  result_valid_o,
  output logic                  err_o,
  output lsu_pkg::lsu_wb_ctrl_t wb_ctrl_o,
  output logic [`LSU_XLEN-1:0]  err_addr_o
);

  import lsu_pkg::*;

  logic [`LSU_CNT_W-1:0] cnt_q;
  logic [`LSU_CNT_W-1:0] cnt_d;
  logic                  trans_valid;
  logic                  count_up;
  logic                  count_down;
  lsu_wb_ctrl_t          wb_ctrl_q;
  logic [`LSU_XLEN-1:0]  err_addr_q;

  //////////////////////////////////////////////////
  // Bus request and outstanding counter
  //////////////////////////////////////////////////

  // Depth limit only, never rvalid, gates req
  assign trans_valid = bus_req_i.req && (cnt_q < `LSU_CNT_W'(`LSU_DEPTH));

  always_comb
  begin
    obi_req_o     = bus_req_i;
    obi_req_o.req = trans_valid;
  end

  assign count_up   = trans_valid && obi_gnt_i;
  assign count_down = obi_rsp_i.rvalid;

  always_comb
  begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      cnt_q <= '0;
    else
      cnt_q <= cnt_d;
  end

  // Address phase done in lockstep with write-back
  // At two outstanding the grant already happened, wait for the oldest response
  always_comb
  begin
    case (cnt_q)
      2'd0:    addr_done_o = count_up;
      2'd1:    addr_done_o = count_up && obi_rsp_i.rvalid;
      default: addr_done_o = bus_req_i.req && obi_rsp_i.rvalid;
    endcase
  end

  // Hold the execute stage through the first half of a split
  assign req_ready_o = addr_done_o && !split_first_i;

  //////////////////////////////////////////////////
  // Write-back control and error address
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_ctrl_q  <= '0;
      err_addr_q <= '0;
    end
    else
    begin
      if (addr_done_o)
      begin
        wb_ctrl_q.size     <= req_size_i;
        wb_ctrl_q.sign_ext <= req_sign_ext_i;
        wb_ctrl_q.we       <= bus_req_i.we;
        wb_ctrl_q.offset   <= addr_lsb_i;
        wb_ctrl_q.last     <= !split_first_i;
      end
      // For the trap handler, the last transfer the bus took
      if (count_up)
        err_addr_q <= obi_req_o.addr;
    end
  end

  // Pulses only with a response
  assign rsp_load_o     = obi_rsp_i.rvalid && !wb_ctrl_q.we;
  assign result_valid_o = obi_rsp_i.rvalid && wb_ctrl_q.last && (cnt_q != '0);
  assign err_o          = obi_rsp_i.rvalid && obi_rsp_i.err;

  assign wb_ctrl_o  = wb_ctrl_q;
  assign err_addr_o = err_addr_q;

endmodule

// ==== source/obi_pkg.sv ====
`include "lsu_consts.svh"

package obi_pkg;

  // OBI address phase, qualified by req and completed by gnt
  typedef struct packed {
    logic                 req;
    logic [`LSU_XLEN-1:0] addr;
    logic                 we;
    logic [`LSU_BE_W-1:0] be;
    logic [`LSU_XLEN-1:0] wdata;
  } obi_req_t;

  // OBI response phase, in order with the grants
  typedef struct packed {
    logic                 rvalid;
    logic [`LSU_XLEN-1:0] rdata;
    // Bus error for this transfer
    logic                 err;
  } obi_rsp_t;

endpackage

// ==== test/tb_lsu_top.sv ====
`timescale 1ns/100ps
`include "lsu_consts.svh"

module tb_lsu_top;

  import lsu_pkg::*;
  import obi_pkg::*;

  localparam int NUM_REQ    = 400;
  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DLY  = 2;
  localparam int MAX_CYCLES = NUM_REQ * 12 + 20;

  // One bus transfer as the execute-stage request should produce it
  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
  } xfer_t;

  // Response held by the memory until its cycle comes
  typedef struct packed {
    logic [31:0] due;
    logic        err;
    logic [31:0] rdata;
  } pend_t;

  // Expected write-back of one request
  typedef struct packed {
    logic        load;
    logic [31:0] rdata;
  } result_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req_valid;
  lsu_req_t    req;
  logic        req_ready;
  obi_req_t    obi_req;
  logic        obi_gnt;
  obi_rsp_t    obi_rsp;
  logic        result_valid;
  logic [31:0] result_rdata;
  logic        err;
  logic [31:0] err_addr;

  logic [31:0] lcg_state = 32'hbaf6;
  // Bus memory and its byte-wide shadow, 256-byte window
  logic [31:0] mem [64];
  logic [7:0]  shadow [256];
  xfer_t       xfer_q [$];
  pend_t       pend_q [$];
  result_t     result_q [$];
  int          err_cnt = 0;
  int          result_cnt = 0;
  int          bus_err_cnt = 0;
  int          cycle = 0;
  int          gnt_wait = 0;
  logic [31:0] last_gnt_addr = '0;
  logic [31:0] last_due = '0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  lsu_top i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid_i    (req_valid),
    .req_i          (req),
    .req_ready_o    (req_ready),
    .obi_req_o      (obi_req),
    .obi_gnt_i      (obi_gnt),
    .obi_rsp_i      (obi_rsp),
    .result_valid_o (result_valid),
    .result_rdata_o (result_rdata),
    .err_o          (err),
    .err_addr_o     (err_addr)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper LCG bits, the low ones repeat too soon
  function automatic logic [31:0] random_below(int n);
    logic [31:0] r;
    r = next_random();
    return r[31:16] % n;
  endfunction

  // Top 16 bytes of the window answer with a bus error
  function automatic logic is_error_addr(logic [31:0] addr);
    return addr[7:4] == 4'hf;
  endfunction

  function automatic logic [7:0] shadow_read(logic [7:0] a);
    return is_error_addr({24'h0, a}) ? 8'h00 : shadow[a];
  endfunction

  function automatic void shadow_write(logic [7:0] a, logic [7:0] d);
    if (!is_error_addr({24'h0, a}))
      shadow[a] = d;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    err_cnt++;
    $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
  endtask

  task automatic report_failure(string what);
    err_cnt++;
    $display("At %0t, %s", $time, what);
  endtask

  task automatic check_idle_outputs();
    assert (!obi_req.req) else report_mismatch("obi_req_o.req", obi_req.req, 0);
    assert (!result_valid) else report_mismatch("result_valid_o", result_valid, 0);
    assert (!err) else report_mismatch("err_o", err, 0);
  endtask

  // Random request, its bus transfers and its result, from the shadow
  task automatic present_request();
    lsu_req_t    r;
    xfer_t       x;
    result_t     e;
    logic [1:0]  sz;
    logic [31:0] a;
    logic [31:0] val;
    int          nbytes;
    int          lane;
    r.we       = random_below(2);
    sz         = random_below(3);
    r.size     = lsu_size_e'(sz);
    r.sign_ext = random_below(2);
    r.base     = 32'h0000_4000 + random_below(256);
    r.offset   = random_below(64) - 32'd32;
    r.wdata    = next_random();
    a      = r.base + r.offset;
    nbytes = 1 << sz;
    val    = '0;
    x      = '0;
    x.we   = r.we;
    x.addr = a;
    for (int k = 0; k < nbytes; k++)
    begin
      // Crossing into the next word opens the second transfer
      if (a[1:0] + k == 4)
      begin
        xfer_q.push_back(x);
        x.be    = '0;
        x.wdata = '0;
        x.addr  = {a[31:2] + 30'd1, 2'b00};
      end
      lane = (a[1:0] + k) % 4;
      x.be[lane] = 1'b1;
      x.wdata[8 * lane +: 8] = r.wdata[8 * k +: 8];
      if (r.we)
        shadow_write(a[7:0] + k, r.wdata[8 * k +: 8]);
      else
        val[8 * k +: 8] = shadow_read(a[7:0] + k);
    end
    xfer_q.push_back(x);
    if (r.sign_ext && r.size == LSU_BYTE)
      val = {{24{val[7]}}, val[7:0]};
    if (r.sign_ext && r.size == LSU_HALF)
      val = {{16{val[15]}}, val[15:0]};
    e.load  = !r.we;
    e.rdata = val;
    result_q.push_back(e);
    req = r;
  endtask

  //////////////////////////////////////////////////
  // OBI memory model
  //////////////////////////////////////////////////

  // Handshakes are taken at the falling edge, outputs driven after the rising one
  always @(negedge clk)
  begin : memory_model
    pend_t       p;
    xfer_t       x;
    logic [5:0]  idx;
    logic [31:0] mask;
    cycle++;
    if (obi_rsp.rvalid)
    begin
      p = pend_q.pop_front();
      assert (err == p.err) else report_mismatch("err_o", err, p.err);
      if (p.err)
      begin
        bus_err_cnt++;
        assert (err_addr == last_gnt_addr)
          else report_mismatch("err_addr_o", err_addr, last_gnt_addr);
      end
    end
    else
    begin
      assert (!err) else report_mismatch("err_o", err, 0);
    end
    if (obi_req.req && obi_gnt)
    begin
      assert (xfer_q.size() != 0)
        else report_failure("a bus transfer was granted while no transfer was expected");
      if (xfer_q.size() != 0)
      begin
        x    = xfer_q.pop_front();
        mask = {{8{x.be[3]}}, {8{x.be[2]}}, {8{x.be[1]}}, {8{x.be[0]}}};
        assert (obi_req.addr == x.addr)
          else report_mismatch("obi_req_o.addr", obi_req.addr, x.addr);
        assert (obi_req.we == x.we) else report_mismatch("obi_req_o.we", obi_req.we, x.we);
        assert (obi_req.be == x.be) else report_mismatch("obi_req_o.be", obi_req.be, x.be);
        assert (!x.we || (obi_req.wdata & mask) == x.wdata)
          else report_mismatch("obi_req_o.wdata", obi_req.wdata & mask, x.wdata);
      end
      // Data is read or written at the grant, so order follows the grants
      idx     = obi_req.addr[7:2];
      p.err   = is_error_addr(obi_req.addr);
      p.rdata = p.err ? '0 : mem[idx];
      for (int k = 0; k < 4; k++)
        if (obi_req.we && !p.err && obi_req.be[k])
          mem[idx][8 * k +: 8] = obi_req.wdata[8 * k +: 8];
      p.due = cycle + 1 + random_below(3);
      if (p.due <= last_due)
        p.due = last_due + 1;
      last_due = p.due;
      pend_q.push_back(p);
      last_gnt_addr = obi_req.addr;
      assert (pend_q.size() <= `LSU_DEPTH)
        else report_mismatch("outstanding transfers", pend_q.size(), `LSU_DEPTH);
      gnt_wait = random_below(3);
    end
    else if (obi_req.req && gnt_wait > 0)
      gnt_wait--;
    @(posedge clk);
    #DRIVE_DLY;
    obi_gnt = (gnt_wait == 0);
    obi_rsp = '0;
    if (pend_q.size() > 0 && pend_q[0].due == cycle + 1)
    begin
      obi_rsp.rvalid = 1'b1;
      obi_rsp.rdata  = pend_q[0].rdata;
      obi_rsp.err    = pend_q[0].err;
    end
  end

  // Results in request order
  always @(negedge clk)
  begin : result_check
    result_t r;
    if (result_valid)
    begin
      assert (result_q.size() != 0)
        else report_failure("result_valid_o pulsed with no request waiting for it");
      if (result_q.size() != 0)
      begin
        r = result_q.pop_front();
        result_cnt++;
        assert (!r.load || result_rdata == r.rdata)
          else report_mismatch("result_rdata_o", result_rdata, r.rdata);
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial
  begin : stimulus
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    obi_gnt   = 1'b0;
    obi_rsp   = '0;
    for (int i = 0; i < 64; i++)
    begin
      mem[i] = (i * 4) * 32'h9e3779b1 + 32'h3c6ef372;
      for (int k = 0; k < 4; k++)
        shadow[4 * i + k] = mem[i][8 * k +: 8];
    end
    repeat (5)
    begin
      @(negedge clk);
      check_idle_outputs();
    end
    @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    repeat (2)
    begin
      @(negedge clk);
      check_idle_outputs();
    end
    @(posedge clk);
    #DRIVE_DLY;
    for (int i = 0; i < NUM_REQ; i++)
    begin
      // Idle gap now and then so the split state clears
      if (random_below(4) == 0)
      begin
        req_valid = 1'b0;
        repeat (1 + random_below(2)) @(posedge clk);
        #DRIVE_DLY;
      end
      present_request();
      req_valid = 1'b1;
      do
        @(negedge clk);
      while (!req_ready);
      @(posedge clk);
      #DRIVE_DLY;
    end
    req_valid = 1'b0;
    while (result_q.size() != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);
    assert (xfer_q.size() == 0 && pend_q.size() == 0)
      else report_failure("bus transfers were left over at the end of the run");
    assert (result_cnt == NUM_REQ) else report_mismatch("result count", result_cnt, NUM_REQ);
    $display("Checks done: %0d errors, %0d results, %0d bus errors",
             err_cnt, result_cnt, bus_err_cnt);
    if (err_cnt == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  // Bound on the whole run, about twelve cycles per request
  initial
  begin : watchdog
    #(MAX_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, the run did not finish within %0d cycles", MAX_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
